// ==== motion_top.f ====
source/motion_pkg.sv
source/spi_word_rx.sv
source/command_parser.sv
source/move_dda.sv
source/hbridge_driver.sv
source/quad_encoder.sv
source/motion_top.sv
testbench/motion_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module motion_tb -f motion_top.f
output=$(./obj_dir/Vmotion_tb)
echo "$output"
if grep -qx "all tests passed" <<< "$output"; then
  exit 0
else
  echo "simulation did not pass"
  exit 1
fi

// ==== testbench/motion_tb.sv ====
module motion_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import motion_pkg::*;

  // Longest SPI frame in CLK cycles, led wait included
  localparam int FRAME_CYCLES = 8 + 64 * 8 + 32 + 12;

  logic   CLK;
  logic   arst_n;
  logic   sck;
  logic   cs_n;
  logic   copi;
  logic   cipo;
  logic   led;
  logic   m1_phase_a1;
  logic   m1_phase_a2;
  logic   m1_phase_b1;
  logic   m1_phase_b2;
  logic   enc_a;
  logic   enc_b;
  logic   enc_fault;
  integer seed;
  int     errors;
  int     err_at_start;
  int     tests_run;
  int     tests_bad;
  // Encoder Gray position and expected count
  int     gray_pos;
  word_t  enc_model;
  // DDA accumulator carried across moves
  acc_t   acc_model;
  // Last half-step table index seen on the phases
  int     last_idx;

  motion_top i_motion_top (.CLK, .arst_n, .sck, .cs_n, .copi, .cipo, .led,
    .m1_phase_a1, .m1_phase_a2, .m1_phase_b1, .m1_phase_b2, .enc_a, .enc_b, .enc_fault);

  always #4 CLK = ~CLK;

  // A leads B, sequence 00 10 11 01
  function automatic logic [1:0] gray_code(input int p);
    case (p)
      0:       gray_code = 2'b00;
      1:       gray_code = 2'b10;
      2:       gray_code = 2'b11;
      default: gray_code = 2'b01;
    endcase
  endfunction

  function automatic logic [3:0] phase_bits();
    phase_bits = {m1_phase_a1, m1_phase_a2, m1_phase_b1, m1_phase_b2};
  endfunction

  // Standard half-step order a1, a1+b1, b1, b1+a2, a2, a2+b2, b2, b2+a1
  function automatic int phase_index(input logic [3:0] p);
    case (p)
      4'b1000: phase_index = 0;
      4'b1010: phase_index = 1;
      4'b0010: phase_index = 2;
      4'b0110: phase_index = 3;
      4'b0100: phase_index = 4;
      4'b0101: phase_index = 5;
      4'b0001: phase_index = 6;
      4'b1001: phase_index = 7;
      default: phase_index = -1;
    endcase
  endfunction

  task automatic check_word(input string what, input word_t got, input word_t exp);
    assert (got === exp) else begin
      $display("Fail at %0t ns: %s is 0x%h, expected 0x%h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_int(input string what, input int got, input int exp);
    assert (got == exp) else begin
      $display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic start_test();
    err_at_start = errors;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == err_at_start) begin
      $display("%s: pass", name);
    end else begin
      tests_bad++;
      $display("%s: FAIL with %0d errors", name, errors - err_at_start);
    end
  endtask

  // One 64-bit SPI frame, SCK at CLK/8, mode 0
  task automatic spi_transfer(input word_t tx, output word_t rx);
    logic prev_led;
    int   t;
    prev_led = led;
    cs_n = 1'b0;
    repeat (8) @(negedge CLK);
    for (int i = 63; i >= 0; i--) begin
      copi = tx[i];
      repeat (4) @(negedge CLK);
      // Reply bit settled since the last falling SCK
      rx[i] = cipo;
      sck = 1'b1;
      repeat (4) @(negedge CLK);
      sck = 1'b0;
    end
    // LED flips one cycle after word_valid
    t = 0;
    while (led == prev_led && t < 32) begin
      @(negedge CLK);
      t++;
    end
    assert (led != prev_led) else begin
      $display("Timeout: the DUT never accepted SPI word 0x%h", tx);
      errors++;
    end
    repeat (4) @(negedge CLK);
    cs_n = 1'b1;
    repeat (8) @(negedge CLK);
  endtask

  // First reply is stale, second carries the current count
  task automatic read_count(output word_t count);
    word_t r;
    spi_transfer(64'd0, r);
    spi_transfer(64'd0, count);
  endtask

  task automatic encoder_step(input bit fwd);
    gray_pos = fwd ? (gray_pos + 1) % 4 : (gray_pos + 3) % 4;
    {enc_a, enc_b} = gray_code(gray_pos);
    enc_model = fwd ? enc_model + 64'd1 : enc_model - 64'd1;
    // Hold past the sync and decode latency
    repeat (4) @(negedge CLK);
  endtask

  // Reference DDA, one iteration per tick
  task automatic run_dda_model(input int dur, input acc_t inc, input acc_t incinc,
                               output int steps);
    acc_t winc;
    steps = 0;
    winc = inc;
    for (int i = 0; i < dur; i++) begin
      if (i != 0) winc = winc + incinc;
      acc_model = acc_model + winc;
      if (acc_model > 0) begin
        steps++;
        acc_model = acc_model - STEP_THRESHOLD;
      end
    end
  endtask

  // Header, duration and increment words of a move
  task automatic send_move_head(input bit dir, input int dur, input acc_t inc);
    word_t r;
    spi_transfer({CMD_COORDINATED_STEP, 55'd0, dir}, r);
    spi_transfer(word_t'(dur), r);
    spi_transfer(word_t'(inc), r);
  endtask

  // Last word queues the move
  task automatic send_move(input bit dir, input int dur, input acc_t inc, input acc_t incinc);
    word_t r;
    send_move_head(dir, dur, inc);
    spi_transfer(word_t'(incinc), r);
  endtask

  // Counts phase changes and checks each one moves the expected way
  task automatic watch_phases(input int expected, input int step_size, input bit dir,
                              input int limit, output int changes, output int half_seen);
    logic [3:0] prev;
    logic [3:0] cur;
    int         idx;
    int         want;
    int         t;
    int         settle;
    prev = phase_bits();
    want = dir ? step_size : 8 - step_size;
    changes = 0;
    half_seen = 0;
    t = 0;
    settle = 0;
    // Keep watching a little after the last expected step
    while (t < limit && settle < 24) begin
      @(negedge CLK);
      t++;
      if (changes >= expected) settle++;
      cur = phase_bits();
      if (cur != prev) begin
        idx = phase_index(cur);
        assert (idx >= 0 && ((idx - last_idx + 8) % 8) == want) else begin
          $display("Fail at %0t ns: phase step to %b, last index %0d, dir %0d",
            $time, cur, last_idx, dir);
          errors++;
        end
        if (idx >= 0) last_idx = idx;
        if (idx % 2 == 1) half_seen++;
        changes++;
        prev = cur;
      end
    end
    assert (settle >= 24) else begin
      $display("Timeout: only %0d of %0d phase changes seen", changes, expected);
      errors++;
    end
  endtask

  task automatic version_query();
    word_t r;
    start_test();
    spi_transfer({CMD_API_VERSION, 56'd0}, r);
    spi_transfer(64'd0, r);
    check_word("version reply", r, {40'd0, VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH});
    // Version shows for one reply only
    spi_transfer(64'd0, r);
    check_word("reply after version", r, enc_model);
    finish_test("version query");
  endtask

  task automatic encoder_counting();
    word_t r;
    int    n;
    int    m;
    start_test();
    n = ($random(seed) & 31) + 1;
    m = $random(seed) & 15;
    repeat (n) encoder_step(1'b1);
    repeat (m) encoder_step(1'b0);
    read_count(r);
    check_word("encoder count", r, enc_model);
    finish_test("encoder counting");
  endtask

  task automatic encoder_fault();
    word_t r;
    int    t;
    start_test();
    check_int("fault before jump", int'(enc_fault), 0);
    // Both lines toggle in one sample
    gray_pos = (gray_pos + 2) % 4;
    {enc_a, enc_b} = gray_code(gray_pos);
    t = 0;
    while (!enc_fault && t < 16) begin
      @(negedge CLK);
      t++;
    end
    assert (enc_fault) else begin
      $display("Timeout: enc_fault did not rise after an illegal transition");
      errors++;
    end
    repeat (20) @(negedge CLK);
    read_count(r);
    check_word("count after fault", r, enc_model);
    check_int("sticky fault", int'(enc_fault), 1);
    finish_test("encoder fault");
  endtask

  task automatic enable_gating();
    word_t r;
    int    steps;
    int    idx;
    int    t;
    start_test();
    spi_transfer({CMD_CLK_DIVISOR, 48'd0, 8'd4}, r);
    run_dda_model(10, 64'sh2000_0000_0000_0000, 64'sd0, steps);
    send_move(1'b1, 10, 64'sh2000_0000_0000_0000, 64'sd0);
    // Motor off, steps must stay invisible for the whole move
    for (t = 0; t < 10 * 4 + 48; t++) begin
      @(negedge CLK);
      assert (phase_bits() == 4'b0000) else begin
        $display("Fail at %0t ns: phases %b while disabled", $time, phase_bits());
        errors++;
      end
    end
    spi_transfer({CMD_MOTOR_ENABLE, 55'd0, 1'b1}, r);
    t = 0;
    while (phase_bits() == 4'b0000 && t < 16) begin
      @(negedge CLK);
      t++;
    end
    // Full-step position drives a single coil of one pair
    idx = phase_index(phase_bits());
    assert (idx >= 0 && idx % 2 == 0) else begin
      $display("Fail at %0t ns: phases %b after enable", $time, phase_bits());
      errors++;
    end
    // Position advanced through the disabled move
    check_int("phase index after enable", idx, (last_idx + 2 * steps) % 8);
    if (idx >= 0) last_idx = idx;
    finish_test("enable gating");
  endtask

  task automatic coordinated_move();
    word_t r;
    bit    dir;
    int    dur;
    int    k;
    acc_t  inc;
    acc_t  incinc;
    int    steps;
    int    changes;
    int    half_seen;
    start_test();
    spi_transfer({CMD_CLK_DIVISOR, 48'd0, 8'd4}, r);
    dir = $random(seed) & 1;
    dur = 8 + ($random(seed) & 7);
    inc = acc_t'(($random(seed) & 7) + 4) <<< 58;
    k = $random(seed) % 3;
    incinc = acc_t'(k) <<< 54;
    run_dda_model(dur, inc, incinc, steps);
    send_move_head(dir, dur, inc);
    // Phases watched during the last word since the move starts right after it
    fork
      spi_transfer(word_t'(incinc), r);
      watch_phases(steps, 2, dir, FRAME_CYCLES + dur * 4 + 64, changes, half_seen);
    join
    check_int("full-step phase changes", changes, steps);
    check_int("half-step entries in full-step mode", half_seen, 0);
    finish_test("coordinated move");
  endtask

  task automatic half_step_move();
    word_t r;
    bit    dir;
    int    dur;
    acc_t  inc;
    int    steps;
    int    changes;
    int    half_seen;
    start_test();
    spi_transfer({CMD_MICROSTEPS, 53'd0, 3'd2}, r);
    dir = $random(seed) & 1;
    dur = 5 + ($random(seed) & 3);
    inc = acc_t'(($random(seed) & 7) + 4) <<< 58;
    run_dda_model(dur, inc, 64'sd0, steps);
    send_move_head(dir, dur, inc);
    fork
      spi_transfer(64'd0, r);
      watch_phases(steps, 1, dir, FRAME_CYCLES + dur * 4 + 64, changes, half_seen);
    join
    check_int("half-step phase changes", changes, steps);
    assert (half_seen > 0) else begin
      $display("Fail at %0t ns: no two-coil half-step entry visited", $time);
      errors++;
    end
    finish_test("half step move");
  endtask

  initial begin
    CLK = 1'b0;
    arst_n = 1'b0;
    sck = 1'b0;
    cs_n = 1'b1;
    copi = 1'b0;
    enc_a = 1'b0;
    enc_b = 1'b0;
    seed = 32'h7de14772;
    errors = 0;
    err_at_start = 0;
    tests_run = 0;
    tests_bad = 0;
    gray_pos = 0;
    enc_model = '0;
    acc_model = '0;
    last_idx = 0;
    repeat (8) @(negedge CLK);
    arst_n = 1'b1;
    repeat (4) @(negedge CLK);
    version_query();
    encoder_counting();
    encoder_fault();
    enable_gating();
    coordinated_move();
    half_step_move();
    $display("%0d tests run, %0d clean, %0d with errors, %0d check errors",
      tests_run, tests_run - tests_bad, tests_bad, errors);
    if (tests_bad == 0 && errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== source/motion_top.sv ====
module motion_top #(
  parameter int MOVE_DEPTH = 4
) (
  input  logic CLK,
  input  logic arst_n,
  input  logic sck,
  input  logic cs_n,
  input  logic copi,
  output logic cipo,
  output logic led,
  output logic m1_phase_a1,
  output logic m1_phase_a2,
  output logic m1_phase_b1,
  output logic m1_phase_b2,
  input  logic enc_a,
  input  logic enc_b,
  output logic enc_fault
);
  import motion_pkg::*;

  logic       word_valid;
  word_t      word_data;
  word_t      reply_data;
  word_t      encoder_count;
  logic       move_wr;
  logic       move_dir;
  word_t      move_duration;
  acc_t       move_increment;
  acc_t       move_incinc;
  logic       move_full;
  logic       enable;
  logic [2:0] microsteps;
  logic [7:0] clock_divisor;
  logic       step;
  logic       dir;
  logic       tick;

  spi_word_rx u_spi (.CLK, .arst_n, .sck, .cs_n, .copi, .cipo,
    .reply_data, .word_valid, .word_data);

  command_parser #(.MOVE_DEPTH(MOVE_DEPTH)) u_parser (.CLK, .arst_n,
    .word_valid, .word_data, .encoder_count, .tick, .move_full, .reply_data,
    .move_wr, .move_dir, .move_duration, .move_increment, .move_incinc,
    .enable, .microsteps, .clock_divisor);

  move_dda #(.MOVE_DEPTH(MOVE_DEPTH)) u_dda (.CLK, .arst_n, .move_wr, .move_dir,
    .move_duration, .move_increment, .move_incinc, .clock_divisor,
    .move_full, .step, .dir, .tick);

  hbridge_driver u_bridge (.CLK, .arst_n, .step, .dir, .enable, .microsteps,
    .phase_a1(m1_phase_a1), .phase_a2(m1_phase_a2),
    .phase_b1(m1_phase_b1), .phase_b2(m1_phase_b2));

  quad_encoder u_enc (.CLK, .arst_n, .a(enc_a), .b(enc_b),
    .count(encoder_count), .fault(enc_fault));

  // Activity LED, flips once per received word
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      led <= 1'b0;
    end else if (word_valid) begin
      led <= ~led;
    end
  end

endmodule

// ==== source/quad_encoder.sv ====
module quad_encoder (
  input  logic              CLK,
  input  logic              arst_n,
  input  logic              a,
  input  logic              b,
  output motion_pkg::word_t count,
  output logic              fault
);

  // Two sync stages plus the previous sample
  logic [2:0] a_q;
  logic [2:0] b_q;
  logic [1:0] cur;
  logic [1:0] prev;
  logic [1:0] change;
  logic       fwd;

  assign cur    = {a_q[1], b_q[1]};
  assign prev   = {a_q[2], b_q[2]};
  assign change = cur ^ prev;
  // A leads when old A equals new B
  assign fwd    = (prev[1] == cur[0]);

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      a_q   <= '0;
      b_q   <= '0;
      count <= '0;
      fault <= 1'b0;
    end else begin
      a_q <= {a_q[1:0], a};
      b_q <= {b_q[1:0], b};
      case (change)
        2'b01, 2'b10: count <= fwd ? count + 64'd1 : count - 64'd1;
        // Both lines moved, direction unknown
        2'b11:        fault <= 1'b1;
        default:      count <= count;
      endcase
    end
  end

endmodule

// ==== source/hbridge_driver.sv ====
module hbridge_driver (
  input  logic       CLK,
  input  logic       arst_n,
  input  logic       step,
  input  logic       dir,
  input  logic       enable,
  input  logic [2:0] microsteps,
  output logic       phase_a1,
  output logic       phase_a2,
  output logic       phase_b1,
  output logic       phase_b2
);

  logic [2:0] pos;
  logic [2:0] pos_next;
  logic [2:0] delta;

  // Half-step table as {a1, a2, b1, b2}
  // Even entries drive a single coil, odd entries one coil in each pair
  function automatic logic [3:0] phase_lut(input logic [2:0] idx);
    case (idx)
      3'd0:    phase_lut = 4'b1000;
      3'd1:    phase_lut = 4'b1010;
      3'd2:    phase_lut = 4'b0010;
      3'd3:    phase_lut = 4'b0110;
      3'd4:    phase_lut = 4'b0100;
      3'd5:    phase_lut = 4'b0101;
      3'd6:    phase_lut = 4'b0001;
      default: phase_lut = 4'b1001;
    endcase
  endfunction

  // Full step skips the odd entries
  assign delta    = (microsteps == 3'd1) ? 3'd2 : 3'd1;
  assign pos_next = !step ? pos : (dir ? pos + delta : pos - delta);

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      pos <= '0;
      {phase_a1, phase_a2, phase_b1, phase_b2} <= 4'b0000;
    end else begin
      // Position survives while disabled
      pos <= pos_next;
      {phase_a1, phase_a2, phase_b1, phase_b2} <= enable ? phase_lut(pos_next) : 4'b0000;
    end
  end

endmodule

// ==== source/move_dda.sv ====
module move_dda #(
  parameter int MOVE_DEPTH = 4
) (
  input  logic              CLK,
  input  logic              arst_n,
  input  logic              move_wr,
  input  logic              move_dir,
  input  motion_pkg::word_t move_duration,
  input  motion_pkg::acc_t  move_increment,
  input  motion_pkg::acc_t  move_incinc,
  input  logic [7:0]        clock_divisor,
  output logic              move_full,
  output logic              step,
  output logic              dir,
  output logic              tick
);
  import motion_pkg::*;

  localparam int PTR_W = $clog2(MOVE_DEPTH);

  // Extra pointer bit tells full from empty
  logic [PTR_W:0]   wr_ptr;
  logic [PTR_W:0]   rd_ptr;
  logic [PTR_W:0]   occupancy;
  logic [PTR_W-1:0] rd_idx;
  logic             empty;
  logic             load;
  logic             mem_dir [MOVE_DEPTH];
  word_t            mem_dur [MOVE_DEPTH];
  acc_t             mem_inc [MOVE_DEPTH];
  acc_t             mem_incinc [MOVE_DEPTH];
  logic             active;
  logic             first;
  word_t            remaining;
  logic [7:0]       div_cnt;
  logic             div_hit;
  acc_t             cur_inc;
  acc_t             cur_incinc;
  acc_t             work_inc;
  acc_t             inc_next;
  acc_t             acc;
  acc_t             acc_sum;

  assign occupancy = wr_ptr - rd_ptr;
  assign rd_idx    = rd_ptr[PTR_W-1:0];
  assign empty     = (occupancy == '0);
  assign move_full = (occupancy == (PTR_W + 1)'(MOVE_DEPTH));
  assign load      = !active && !empty;
  // Divisor 0 wraps to 255, a period of 256
  assign div_hit   = active && (div_cnt == clock_divisor - 8'd1);
  // First tick takes the raw increment, later ticks accelerate
  assign inc_next  = first ? cur_inc : work_inc + cur_incinc;
  assign acc_sum   = acc + inc_next;

  always_ff @(posedge CLK) begin
    if (move_wr) begin
      mem_dir[wr_ptr[PTR_W-1:0]]    <= move_dir;
      mem_dur[wr_ptr[PTR_W-1:0]]    <= move_duration;
      mem_inc[wr_ptr[PTR_W-1:0]]    <= move_increment;
      mem_incinc[wr_ptr[PTR_W-1:0]] <= move_incinc;
    end
    if (load) begin
      cur_inc    <= mem_inc[rd_idx];
      cur_incinc <= mem_incinc[rd_idx];
    end
    if (div_hit) work_inc <= inc_next;
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      active <= 1'b0;
      first <= 1'b0;
      remaining <= '0;
      div_cnt <= '0;
      acc <= '0;
      tick <= 1'b0;
      step <= 1'b0;
      dir <= 1'b0;
    end else begin
      tick <= 1'b0;
      step <= 1'b0;
      if (move_wr) wr_ptr <= wr_ptr + 1'b1;
      if (load) begin
        // Slot frees as soon as the move is taken
        dir       <= mem_dir[rd_idx];
        remaining <= mem_dur[rd_idx];
        active    <= (mem_dur[rd_idx] != '0);
        first     <= 1'b1;
        div_cnt   <= '0;
        rd_ptr    <= rd_ptr + 1'b1;
      end else if (div_hit) begin
        tick    <= 1'b1;
        div_cnt <= '0;
        first   <= 1'b0;
        // Positive accumulator means one full step owed
        if (acc_sum > 0) begin
          step <= 1'b1;
          acc  <= acc_sum - STEP_THRESHOLD;
        end else begin
          acc <= acc_sum;
        end
        remaining <= remaining - 1'b1;
        if (remaining == word_t'(1)) active <= 1'b0;
      end else if (active) begin
        div_cnt <= div_cnt + 8'd1;
      end
    end
  end

  // Guards against a parser write into a full buffer
  a_occupancy: assert property (@(posedge CLK) disable iff (!arst_n)
    int'(occupancy) <= MOVE_DEPTH);

endmodule

// ==== source/command_parser.sv ====
module command_parser #(
  parameter int MOVE_DEPTH = 4
) (
  input  logic              CLK,
  input  logic              arst_n,
  input  logic              word_valid,
  input  motion_pkg::word_t word_data,
  input  motion_pkg::word_t encoder_count,
  input  logic              tick,
  input  logic              move_full,
  output motion_pkg::word_t reply_data,
  output logic              move_wr,
  output logic              move_dir,
  output motion_pkg::word_t move_duration,
  output motion_pkg::acc_t  move_increment,
  output motion_pkg::acc_t  move_incinc,
  output logic              enable,
  output logic [2:0]        microsteps,
  output logic [7:0]        clock_divisor
);
  import motion_pkg::*;

  parser_state_t state;
  header_t       header;
  word_t         count_last;
  word_t         version_word;

  // Header is the top byte
  assign header       = word_data[63:56];
  assign version_word = {40'd0, VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH};

  // Ring buffer indexing needs a power of two
  if ((MOVE_DEPTH < 2) || ((MOVE_DEPTH & (MOVE_DEPTH - 1)) != 0)) begin : g_depth_check
    $error("MOVE_DEPTH must be a power of two of at least 2");
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state         <= PS_HEADER;
      reply_data    <= '0;
      move_wr       <= 1'b0;
      enable        <= 1'b0;
      microsteps    <= 3'd1;
      clock_divisor <= DEFAULT_DIVISOR;
      count_last    <= '0;
    end else begin
      move_wr <= 1'b0;
      // Encoder snapshot at every DDA tick
      if (tick) begin
        count_last <= encoder_count;
      end
      if (word_valid) begin
        // Encoder count unless a message says otherwise
        reply_data <= encoder_count;
        case (state)
          PS_HEADER: begin
            case (header)
              CMD_COORDINATED_STEP: state <= PS_DURATION;
              CMD_MOTOR_ENABLE:     enable <= word_data[0];
              CMD_CLK_DIVISOR:      clock_divisor <= word_data[7:0];
              CMD_MICROSTEPS:       microsteps <= word_data[2:0];
              CMD_API_VERSION: begin
                reply_data <= version_word;
                state      <= PS_REPLY_DONE;
              end
              default: state <= PS_HEADER;
            endcase
          end
          PS_DURATION:  state <= PS_INCREMENT;
          PS_INCREMENT: begin
            // Host reads back the count at the last tick
            reply_data <= count_last;
            state      <= PS_INCINC;
          end
          PS_INCINC: begin
            // Full buffer drops the move
            move_wr <= ~move_full;
            state   <= PS_HEADER;
          end
          // Word after a version query is ignored
          default: state <= PS_HEADER;
        endcase
      end
    end
  end

  // Move fields, collected word by word
  always_ff @(posedge CLK) begin
    if (word_valid) begin
      if ((state == PS_HEADER) && (header == CMD_COORDINATED_STEP)) move_dir <= word_data[0];
      if (state == PS_DURATION) move_duration <= word_data;
      if (state == PS_INCREMENT) move_increment <= acc_t'(word_data);
      if (state == PS_INCINC) move_incinc <= acc_t'(word_data);
    end
  end

  // Full flag can only rise on a write, so a write is never issued into a full buffer
  a_no_wr_full: assert property (@(posedge CLK) disable iff (!arst_n)
    move_wr |-> !move_full);

endmodule

// ==== source/spi_word_rx.sv ====
module spi_word_rx (
  input  logic              CLK,
  input  logic              arst_n,
  input  logic              sck,
  input  logic              cs_n,
  input  logic              copi,
  output logic              cipo,
  input  motion_pkg::word_t reply_data,
  output logic              word_valid,
  output motion_pkg::word_t word_data
);
  import motion_pkg::*;

  // Two sync stages plus one history bit for edge detection
  logic [2:0] sck_q;
  logic [2:0] cs_q;
  logic [1:0] copi_q;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_fall;
  logic       cs_active;
  logic [5:0] bit_cnt;
  word_t      rx_shift;
  word_t      tx_shift;

  assign sck_rise  = (sck_q[2:1] == 2'b01);
  assign sck_fall  = (sck_q[2:1] == 2'b10);
  assign cs_fall   = (cs_q[2:1] == 2'b10);
  assign cs_active = ~cs_q[1];
  // MSB first out
  assign cipo      = tx_shift[63];

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      sck_q      <= '0;
      cs_q       <= '1;
      copi_q     <= '0;
      bit_cnt    <= '0;
      word_valid <= 1'b0;
    end else begin
      sck_q      <= {sck_q[1:0], sck};
      cs_q       <= {cs_q[1:0], cs_n};
      copi_q     <= {copi_q[0], copi};
      word_valid <= 1'b0;
      // New frame restarts the bit count
      if (cs_fall) begin
        bit_cnt <= '0;
      end else if (cs_active && sck_rise) begin
        bit_cnt    <= bit_cnt + 6'd1;
        word_valid <= (bit_cnt == 6'd63);
      end
    end
  end

  always_ff @(posedge CLK) begin
    // Mode 0, sample on rising SCK
    if (cs_active && sck_rise) begin
      rx_shift <= {rx_shift[62:0], copi_q[1]};
    end
    if (cs_active && sck_rise && (bit_cnt == 6'd63)) begin
      word_data <= {rx_shift[62:0], copi_q[1]};
    end
    // Reply captured at frame start, shifted on falling SCK
    if (cs_fall) begin
      tx_shift <= reply_data;
    end else if (cs_active && sck_fall) begin
      tx_shift <= {tx_shift[62:0], 1'b0};
    end
  end

  // One pulse per word
  a_valid_single: assert property (@(posedge CLK) disable iff (!arst_n)
    word_valid |=> !word_valid);

endmodule

// ==== source/motion_pkg.sv ====
package motion_pkg;

  // SPI word, also the width of duration, encoder count and reply
  typedef logic [63:0] word_t;

  // Signed DDA quantities
  typedef logic signed [63:0] acc_t;

  // Command header from the top byte of a word
  typedef logic [7:0] header_t;

  localparam header_t CMD_COORDINATED_STEP = 8'd1;
  localparam header_t CMD_MOTOR_ENABLE     = 8'd2;
  localparam header_t CMD_CLK_DIVISOR      = 8'd3;
  localparam header_t CMD_MICROSTEPS       = 8'd4;
  localparam header_t CMD_API_VERSION      = 8'd5;

  localparam logic [7:0] VERSION_MAJOR = 8'd0;
  localparam logic [7:0] VERSION_MINOR = 8'd3;
  localparam logic [7:0] VERSION_PATCH = 8'd1;

  // Accumulator threshold for one step, 2**62
  localparam acc_t STEP_THRESHOLD = 64'sh4000_0000_0000_0000;

  // Tick divider after reset
  localparam logic [7:0] DEFAULT_DIVISOR = 8'd40;

  // Message parser states
  typedef enum logic [2:0] {
    PS_HEADER, PS_DURATION, PS_INCREMENT, PS_INCINC, PS_REPLY_DONE
  } parser_state_t;

endpackage
